/* vlog.f */
+incdir+hdl
hdl/cmd_track_pkg.sv
hdl/nvme_cmp.sv
hdl/cmd_track_cfg.sv
hdl/cmd_slot_table.sv
hdl/cmd_timeout_mon.sv
hdl/cmd_track_top.sv
sim/cmd_track_tb.sv

/* sim/cmd_track_tests.txt */
# op a b, numbers in hex; W addr data, I tag, C tag, N cycles, T tag, R addr value,
# S max ready stall, Q issue ready, Z no timeout pending; unused fields are 0
# reset state
R 0 0
R 1 0
R 2 0
Q 1 0
Z 0 0
# lowest free slot, reuse after completion
I 10 0
I 11 0
I 12 0
C 11 0
I 13 0
I 14 0
I 15 0
I 16 0
I 17 0
I 18 0
Q 0 0
C 15 0
I 19 0
Q 0 0
# completed commands must never time out
C 13 0
C 17 0
W 1 40
W 0 1
R 0 1
R 1 40
# events in issue order under random ready stalls
S 8 0
T 10 0
T 12 0
T 14 0
T 16 0
T 18 0
T 19 0
Z 0 0
R 2 6
# disabled, long wait, nothing fires
W 0 0
R 0 0
I 20 0
I 21 0
N 200 0
Z 0 0
R 2 6
R 1 40

/* sim/cmd_track_tb.sv */
/* testbench for the command timeout tracker, runs the operations listed in
   sim/cmd_track_tests.txt against a slot model and checks every response */
`timescale 1ns/1ps
`include "cmd_track_macros.svh"

module cmd_track_tb;

localparam int clk_period = 40;
// watchdog budget per test line
localparam int cycles_per_line = 200;

logic                          clk;
logic                          rst_n;
cmd_track_pkg::cmd_issue_t     issue;
logic                          issue_valid;
logic                          issue_ready;
logic [`CMD_SLOT_W-1:0]        issue_slot;
cmd_track_pkg::cmd_cpl_t       cpl;
logic                          cpl_valid;
cmd_track_pkg::cmd_timeout_t   to;
logic                          to_valid;
logic                          to_ready;
cmd_track_pkg::cmd_reg_req_t   reg_req;
logic [`CMD_REG_AW-1:0]        reg_addr_rd;
logic [`CMD_TS_W-1:0]          reg_rdata;

// operations loaded from the test file
logic [63:0]                   op_q [$];
logic [31:0]                   a_q [$];
logic [31:0]                   b_q [$];
logic                          loaded;
// slot model, tag to slot
logic                          slot_busy [`CMD_SLOTS];
logic [`CMD_TAG_W-1:0]         slot_tag [`CMD_SLOTS];
logic [`CMD_TS_W-1:0]          model_thresh;
int                            stall_max;
int                            handshakes;
integer                        seed;
// file reader state
integer                        fd;
integer                        code;
logic [63:0]                   tok;
logic [8*128-1:0]              line;
logic [31:0]                   fa;
logic [31:0]                   fb;

cmd_track_top dut0 (
   .clk         (clk),
   .rst_n       (rst_n),
   .issue       (issue),
   .issue_valid (issue_valid),
   .issue_ready (issue_ready),
   .issue_slot  (issue_slot),
   .cpl         (cpl),
   .cpl_valid   (cpl_valid),
   .to          (to),
   .to_valid    (to_valid),
   .to_ready    (to_ready),
   .reg_req     (reg_req),
   .reg_addr_rd (reg_addr_rd),
   .reg_rdata   (reg_rdata)
);

always #(clk_period / 2) clk = ~clk;

task automatic abort_run();
   $display("CHECKS FAILED");
   $fatal(1, "run stopped at the first error");
endtask

task automatic check_slot(input logic [`CMD_SLOT_W-1:0] actual,
                          input logic [`CMD_SLOT_W-1:0] exp);
   if (actual !== exp)
   begin
      $display("FAIL at %0d ns: issue slot %0d, expected %0d", $time, actual, exp);
      abort_run();
   end
endtask

// exp.age is the lowest acceptable age
task automatic check_timeout(input cmd_track_pkg::cmd_timeout_t actual,
                             input cmd_track_pkg::cmd_timeout_t exp);
   if ($isunknown(actual) || actual.tag !== exp.tag || actual.slot !== exp.slot ||
       actual.age < exp.age)
   begin
      $display("FAIL at %0d ns: timeout tag %h slot %0d age %0d, expected %h %0d >= %0d",
               $time, actual.tag, actual.slot, actual.age, exp.tag, exp.slot, exp.age);
      abort_run();
   end
endtask

task automatic check_reg(input logic [`CMD_REG_AW-1:0] addr,
                         input logic [`CMD_TS_W-1:0] actual,
                         input logic [`CMD_TS_W-1:0] exp);
   if (actual !== exp)
   begin
      $display("FAIL at %0d ns: register %0d reads %h, expected %h", $time, addr, actual, exp);
      abort_run();
   end
endtask

task automatic check_flag(input logic actual, input logic exp, input string what);
   if (actual !== exp)
   begin
      $display("FAIL at %0d ns: %s is %b, expected %b", $time, what, actual, exp);
      abort_run();
   end
endtask

// issue always lands in the lowest free index
function automatic logic [`CMD_SLOT_W-1:0] lowest_free();
   logic [`CMD_SLOT_W-1:0] slot;
   slot = '0;
   for (int i = `CMD_SLOTS - 1; i >= 0; i--)
   begin
      if (!slot_busy[i])
      begin
         slot = i[`CMD_SLOT_W-1:0];
      end
   end
   return slot;
endfunction

task automatic find_slot(input logic [`CMD_TAG_W-1:0] tag, output logic [`CMD_SLOT_W-1:0] slot);
   logic found;
   found = 1'b0;
   slot = '0;
   for (int i = 0; i < `CMD_SLOTS; i++)
   begin
      if (slot_busy[i] && slot_tag[i] == tag)
      begin
         slot = i[`CMD_SLOT_W-1:0];
         found = 1'b1;
      end
   end
   if (!found)
   begin
      $display("tag %h from the test file is not outstanding in the model", tag);
      abort_run();
   end
endtask

task automatic do_issue(input logic [`CMD_TAG_W-1:0] tag);
   logic [`CMD_SLOT_W-1:0] exp_slot;
   @(posedge clk);
   issue.tag <= tag;
   issue_valid <= 1'b1;
   @(negedge clk);
   while (issue_ready !== 1'b1)
   begin
      @(negedge clk);
   end
   exp_slot = lowest_free();
   check_slot(issue_slot, exp_slot);
   // handshake on this edge
   @(posedge clk);
   issue_valid <= 1'b0;
   slot_busy[exp_slot] = 1'b1;
   slot_tag[exp_slot] = tag;
endtask

task automatic do_complete(input logic [`CMD_TAG_W-1:0] tag);
   logic [`CMD_SLOT_W-1:0] slot;
   find_slot(tag, slot);
   @(posedge clk);
   cpl.slot <= slot;
   cpl_valid <= 1'b1;
   @(posedge clk);
   cpl_valid <= 1'b0;
   slot_busy[slot] = 1'b0;
endtask

task automatic take_timeout(input logic [`CMD_TAG_W-1:0] tag);
   cmd_track_pkg::cmd_timeout_t exp;
   cmd_track_pkg::cmd_timeout_t held;
   logic [`CMD_SLOT_W-1:0]      slot;
   int                          stall;
   find_slot(tag, slot);
   exp.slot = slot;
   exp.tag = tag;
   exp.age = model_thresh;
   @(negedge clk);
   while (to_valid !== 1'b1)
   begin
      @(negedge clk);
   end
   held = to;
   stall = $unsigned($random(seed)) % (stall_max + 1);
   // event must stay put while ready is low
   repeat (stall)
   begin
      @(negedge clk);
      check_flag(to_valid, 1'b1, "timeout valid during ready stall");
      check_timeout(to, held);
   end
   @(posedge clk);
   to_ready <= 1'b1;
   @(negedge clk);
   check_flag(to_valid, 1'b1, "timeout valid at handshake");
   check_timeout(to, exp);
   @(posedge clk);
   to_ready <= 1'b0;
   handshakes++;
   slot_busy[slot] = 1'b0;
endtask

task automatic write_reg(input logic [`CMD_REG_AW-1:0] addr, input logic [`CMD_TS_W-1:0] data);
   @(posedge clk);
   reg_req.we <= 1'b1;
   reg_req.addr <= addr;
   reg_req.wdata <= data;
   @(posedge clk);
   reg_req.we <= 1'b0;
   if (addr == `CMD_REG_THRESH)
   begin
      model_thresh = data;
   end
endtask

task automatic read_reg(input logic [`CMD_REG_AW-1:0] addr, input logic [`CMD_TS_W-1:0] exp);
   @(posedge clk);
   reg_addr_rd <= addr;
   @(negedge clk);
   check_reg(addr, reg_rdata, exp);
   // count must also match the handshakes seen here
   if (addr == `CMD_REG_COUNT)
   begin
      check_reg(addr, reg_rdata, handshakes[`CMD_TS_W-1:0]);
   end
endtask

task automatic run_op(input logic [63:0] op, input logic [31:0] a, input logic [31:0] b);
   case (op)
      "W": write_reg(a[`CMD_REG_AW-1:0], b[`CMD_TS_W-1:0]);
      "I": do_issue(a[`CMD_TAG_W-1:0]);
      "C": do_complete(a[`CMD_TAG_W-1:0]);
      "N": repeat (a) @(posedge clk);
      "T": take_timeout(a[`CMD_TAG_W-1:0]);
      "R": read_reg(a[`CMD_REG_AW-1:0], b[`CMD_TS_W-1:0]);
      "S": stall_max = a;
      "Q":
      begin
         @(negedge clk);
         check_flag(issue_ready, a[0], "issue ready");
      end
      "Z":
      begin
         @(negedge clk);
         check_flag(to_valid, 1'b0, "timeout valid");
      end
      default:
      begin
         $display("unknown operation in the test file");
         abort_run();
      end
   endcase
endtask

// watchdog, sized from the number of test lines
initial
begin
   wait (loaded === 1'b1);
   repeat ((op_q.size() + 10) * cycles_per_line) @(posedge clk);
   $display("timeout: the test sequence did not finish in time");
   abort_run();
end

initial
begin
   clk = 1'b0;
   rst_n = 1'b0;
   issue = '0;
   issue_valid = 1'b0;
   cpl = '0;
   cpl_valid = 1'b0;
   to_ready = 1'b0;
   reg_req = '0;
   reg_addr_rd = '0;
   loaded = 1'b0;
   model_thresh = '0;
   stall_max = 0;
   handshakes = 0;
   seed = 32'h3832;
   for (int i = 0; i < `CMD_SLOTS; i++)
   begin
      slot_busy[i] = 1'b0;
      slot_tag[i] = '0;
   end
   fd = $fopen("sim/cmd_track_tests.txt", "r");
   if (fd == 0)
   begin
      $display("could not open the test file sim/cmd_track_tests.txt");
      abort_run();
   end
   // comment lines start with a lone #
   while (!$feof(fd))
   begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1)
      begin
         break;
      end
      if (tok == "#")
      begin
         code = $fgets(line, fd);
      end
      else
      begin
         code = $fscanf(fd, "%h %h", fa, fb);
         if (code != 2)
         begin
            $display("malformed line in the test file");
            abort_run();
         end
         op_q.push_back(tok);
         a_q.push_back(fa);
         b_q.push_back(fb);
      end
   end
   $fclose(fd);
   loaded = 1'b1;
   repeat (10) @(posedge clk);
   rst_n <= 1'b1;
   for (int i = 0; i < op_q.size(); i++)
   begin
      run_op(op_q[i], a_q[i], b_q[i]);
   end
   repeat (2) @(posedge clk);
   $display("ALL CHECKS PASSED");
   $finish;
end

endmodule

/* hdl/cmd_track_top.sv */
/* top level of the command timeout tracker
   joins the slot table, the timeout monitor and the register block */
`timescale 1ns/1ps
`include "cmd_track_macros.svh"

module cmd_track_top (
   input  logic                          clk,
   input  logic                          rst_n,
   // issue channel, valid/ready
   input  cmd_track_pkg::cmd_issue_t     issue,
   input  logic                          issue_valid,
   output logic                          issue_ready,
   output logic [`CMD_SLOT_W-1:0]        issue_slot,
   // completion channel, valid only
   input  cmd_track_pkg::cmd_cpl_t       cpl,
   input  logic                          cpl_valid,
   // timeout channel, valid/ready
   output cmd_track_pkg::cmd_timeout_t   to,
   output logic                          to_valid,
   input  logic                          to_ready,
   // register port
   input  cmd_track_pkg::cmd_reg_req_t   reg_req,
   input  logic [`CMD_REG_AW-1:0]        reg_addr_rd,
   output logic [`CMD_TS_W-1:0]          reg_rdata
);

// timestamp from the monitor to the table
logic [`CMD_TS_W-1:0]          now;
// oldest-command record, table to monitor
logic                          oldest_valid;
cmd_track_pkg::cmd_timeout_t   oldest;
// retire strobe, monitor to table
logic                          retire;
logic [`CMD_SLOT_W-1:0]        retire_slot;
cmd_track_pkg::cmd_cfg_t       cfg;
// timeout handshake, counted by the register block
logic                          to_fire;

assign to_fire = to_valid & to_ready;

cmd_slot_table u_table (
   .clk          (clk),
   .rst_n        (rst_n),
   .now          (now),
   .issue        (issue),
   .issue_valid  (issue_valid),
   .issue_ready  (issue_ready),
   .issue_slot   (issue_slot),
   .cpl          (cpl),
   .cpl_valid    (cpl_valid),
   .oldest_valid (oldest_valid),
   .oldest       (oldest),
   .retire       (retire),
   .retire_slot  (retire_slot)
);

cmd_timeout_mon u_mon (
   .clk          (clk),
   .rst_n        (rst_n),
   .cfg          (cfg),
   .now          (now),
   .oldest_valid (oldest_valid),
   .oldest       (oldest),
   .cpl          (cpl),
   .cpl_valid    (cpl_valid),
   .retire       (retire),
   .retire_slot  (retire_slot),
   .to           (to),
   .to_valid     (to_valid),
   .to_ready     (to_ready)
);

cmd_track_cfg u_cfg (
   .clk          (clk),
   .rst_n        (rst_n),
   .reg_req      (reg_req),
   .reg_addr_rd  (reg_addr_rd),
   .reg_rdata    (reg_rdata),
   .cfg          (cfg),
   .to_fire      (to_fire)
);

endmodule

/* hdl/cmd_timeout_mon.sv */
/* timestamp counter and timeout decision for the slot table
   registers the oldest record, fires one event at a time and retires its slot */
`timescale 1ns/1ps
`include "cmd_track_macros.svh"

module cmd_timeout_mon (
   input  logic                          clk,
   input  logic                          rst_n,
   input  cmd_track_pkg::cmd_cfg_t       cfg,
   output logic [`CMD_TS_W-1:0]          now,
   input  logic                          oldest_valid,
   input  cmd_track_pkg::cmd_timeout_t   oldest,
   input  cmd_track_pkg::cmd_cpl_t       cpl,
   input  logic                          cpl_valid,
   output logic                          retire,
   output logic [`CMD_SLOT_W-1:0]        retire_slot,
   output cmd_track_pkg::cmd_timeout_t   to,
   output logic                          to_valid,
   input  logic                          to_ready
);

logic [`CMD_TS_W-1:0]          now_q;
// registered oldest record
logic                          rec_valid_q;
cmd_track_pkg::cmd_timeout_t   rec_q;
// pending event
logic                          to_valid_q;
cmd_track_pkg::cmd_timeout_t   to_q;
logic                          drop_new;
logic                          cpl_hit_rec;
logic                          fire;

// record is dropped if its slot is completed or retired this cycle
assign drop_new = (cpl_valid && (cpl.slot == oldest.slot)) ||
                  (fire && (rec_q.slot == oldest.slot));
// late completion of the registered slot still beats the event
assign cpl_hit_rec = cpl_valid && (cpl.slot == rec_q.slot);

// one event in flight at most
assign fire = cfg.en && rec_valid_q && (rec_q.age >= cfg.thresh) &&
              !to_valid_q && !cpl_hit_rec;

// retire frees the slot on the edge where the event becomes valid
assign retire = fire;
assign retire_slot = rec_q.slot;
assign now = now_q;
assign to = to_q;
assign to_valid = to_valid_q;

always_ff @(posedge clk)
begin
   if (!rst_n)
   begin
      now_q <= '0;
      rec_valid_q <= 1'b0;
      to_valid_q <= 1'b0;
   end
   else
   begin
      // free running, wraps
      now_q <= now_q + 1'b1;
      rec_valid_q <= oldest_valid && !drop_new;
      if (fire)
      begin
         to_valid_q <= 1'b1;
      end
      else if (to_ready)
      begin
         to_valid_q <= 1'b0;
      end
   end
end

// payload registers
always_ff @(posedge clk)
begin
   rec_q <= oldest;
   // held while waiting for ready
   if (fire)
   begin
      to_q <= rec_q;
   end
end

endmodule

/* hdl/cmd_slot_table.sv */
/* per-slot command storage with free-slot allocation and oldest-command search
   issue allocates the lowest free slot, completion and retire release slots */
`timescale 1ns/1ps
`include "cmd_track_macros.svh"

module cmd_slot_table (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [`CMD_TS_W-1:0]          now,
   input  cmd_track_pkg::cmd_issue_t     issue,
   input  logic                          issue_valid,
   output logic                          issue_ready,
   output logic [`CMD_SLOT_W-1:0]        issue_slot,
   input  cmd_track_pkg::cmd_cpl_t       cpl,
   input  logic                          cpl_valid,
   output logic                          oldest_valid,
   output cmd_track_pkg::cmd_timeout_t   oldest,
   input  logic                          retire,
   input  logic [`CMD_SLOT_W-1:0]        retire_slot
);

// one busy bit per slot
logic [`CMD_SLOTS-1:0]               busy_q;
// tag and issue stamp per slot, only meaningful while busy
logic [`CMD_TAG_W-1:0]               tag_q [`CMD_SLOTS];
logic [`CMD_TS_W-1:0]                stamp_q [`CMD_SLOTS];
// flattened slot index list fed to both trees
logic [`CMD_SLOTS*`CMD_SLOT_W-1:0]   slot_ids;
// flattened ages, idle slots read as zero
logic [`CMD_SLOTS*`CMD_TS_W-1:0]     age_vec;
// min of the busy bits, zero means some slot is free
logic                                free_min;
logic [`CMD_TS_W-1:0]                max_age;
logic [`CMD_SLOT_W-1:0]              max_slot;
logic                                issue_fire;

// ids and masked ages
always_comb
begin
   for (int i = 0; i < `CMD_SLOTS; i++)
   begin
      slot_ids[i*`CMD_SLOT_W +: `CMD_SLOT_W] = i[`CMD_SLOT_W-1:0];
      // modulo subtraction, counter wrap does not matter
      age_vec[i*`CMD_TS_W +: `CMD_TS_W] = busy_q[i] ? (now - stamp_q[i]) : '0;
   end
end

// free slot search
// min over busy bits, a tie between free slots goes to the lowest index
nvme_cmp #(
   .max      (0),
   .count    (`CMD_SLOTS),
   .width    (1),
   .id_width (`CMD_SLOT_W)
) cmp_free (
   .data    (busy_q),
   .id      (slot_ids),
   .dout    (free_min),
   .dout_id (issue_slot)
);

// oldest command search
// max over ages, busy slots always have age one or more
nvme_cmp #(
   .max      (1),
   .count    (`CMD_SLOTS),
   .width    (`CMD_TS_W),
   .id_width (`CMD_SLOT_W)
) cmp_old (
   .data    (age_vec),
   .id      (slot_ids),
   .dout    (max_age),
   .dout_id (max_slot)
);

// ready whenever the smallest busy bit is zero
assign issue_ready = ~free_min;
assign issue_fire = issue_valid & issue_ready;

// oldest record to the monitor
assign oldest_valid = |busy_q;
assign oldest.slot = max_slot;
assign oldest.tag = tag_q[max_slot];
assign oldest.age = max_age;

// busy bits
// release first, then allocate; the allocated slot is free so no clash
always_ff @(posedge clk)
begin
   if (!rst_n)
   begin
      busy_q <= '0;
   end
   else
   begin
      // completion of an idle slot just rewrites a zero
      if (cpl_valid)
      begin
         busy_q[cpl.slot] <= 1'b0;
      end
      if (retire)
      begin
         busy_q[retire_slot] <= 1'b0;
      end
      if (issue_fire)
      begin
         busy_q[issue_slot] <= 1'b1;
      end
   end
end

// payload of the slot, written at allocation
always_ff @(posedge clk)
begin
   if (issue_fire)
   begin
      tag_q[issue_slot] <= issue.tag;
      stamp_q[issue_slot] <= now;
   end
end

endmodule

/* hdl/cmd_track_cfg.sv */
/* control registers of the tracker: enable, threshold and timeout count
   write through reg_req, read data is combinational from reg_addr_rd */
`timescale 1ns/1ps
`include "cmd_track_macros.svh"

module cmd_track_cfg (
   input  logic                         clk,
   input  logic                         rst_n,
   input  cmd_track_pkg::cmd_reg_req_t  reg_req,
   input  logic [`CMD_REG_AW-1:0]       reg_addr_rd,
   output logic [`CMD_TS_W-1:0]         reg_rdata,
   output cmd_track_pkg::cmd_cfg_t      cfg,
   input  logic                         to_fire
);

// enable bit of the ctrl register
logic                 en_q;
// age threshold in timestamp ticks
logic [`CMD_TS_W-1:0] thresh_q;
// number of timeout handshakes, sticks at all ones
logic [`CMD_TS_W-1:0] count_q;
logic                 wr_ctrl;
logic                 wr_thresh;

assign wr_ctrl = reg_req.we && (reg_req.addr == `CMD_REG_CTRL);
assign wr_thresh = reg_req.we && (reg_req.addr == `CMD_REG_THRESH);

always_ff @(posedge clk)
begin
   if (!rst_n)
   begin
      en_q <= 1'b0;
      thresh_q <= '0;
      count_q <= '0;
   end
   else
   begin
      if (wr_ctrl)
      begin
         en_q <= reg_req.wdata[0];
      end
      if (wr_thresh)
      begin
         thresh_q <= reg_req.wdata;
      end
      // saturate instead of wrapping back to zero
      if (to_fire && (count_q != '1))
      begin
         count_q <= count_q + 1'b1;
      end
   end
end

// read mux, unmapped addresses return zero
always_comb
begin
   case (reg_addr_rd)
      `CMD_REG_CTRL:   reg_rdata = {{(`CMD_TS_W-1){1'b0}}, en_q};
      `CMD_REG_THRESH: reg_rdata = thresh_q;
      `CMD_REG_COUNT:  reg_rdata = count_q;
      default:         reg_rdata = '0;
   endcase
end

// monitor view
assign cfg.en = en_q;
assign cfg.thresh = thresh_q;

endmodule

/* hdl/nvme_cmp.sv */
/* recursive comparator tree, returns the smallest (max=0) or largest (max=1)
   value of count inputs with its id; count must be a power of two */
`timescale 1ns/1ps

module nvme_cmp #(
   parameter max = 0,
   parameter count = 2,
   parameter width = 1,
   parameter id_width = 1
)
(
   input  logic [count*width-1:0]    data,
   input  logic [count*id_width-1:0] id,
   output logic [width-1:0]          dout,
   output logic [id_width-1:0]       dout_id
);

generate
   if (count > 2)
   begin : g_split
      localparam int half = count / 2;

      // winners of the lower and upper halves
      logic [width-1:0]    lo_val;
      logic [width-1:0]    hi_val;
      logic [id_width-1:0] lo_id;
      logic [id_width-1:0] hi_id;

      nvme_cmp #(.max(max), .count(half), .width(width), .id_width(id_width)) cmp_lo (
         .data    (data[half*width-1:0]),
         .id      (id[half*id_width-1:0]),
         .dout    (lo_val),
         .dout_id (lo_id)
      );

      nvme_cmp #(.max(max), .count(half), .width(width), .id_width(id_width)) cmp_hi (
         .data    (data[count*width-1:half*width]),
         .id      (id[count*id_width-1:half*id_width]),
         .dout    (hi_val),
         .dout_id (hi_id)
      );

      // final two-input stage, lower half sits in the low position
      nvme_cmp #(.max(max), .count(2), .width(width), .id_width(id_width)) cmp_join (
         .data    ({hi_val, lo_val}),
         .id      ({hi_id, lo_id}),
         .dout    (dout),
         .dout_id (dout_id)
      );
   end
   else
   begin : g_pair
      logic [width-1:0] val0;
      logic [width-1:0] val1;
      logic             keep_lo;

      assign val0 = data[width-1:0];
      assign val1 = data[2*width-1:width];
      // ties keep the low input in both modes
      assign keep_lo = max ? (val0 >= val1) : (val0 <= val1);
      assign dout = keep_lo ? val0 : val1;
      assign dout_id = keep_lo ? id[id_width-1:0] : id[2*id_width-1:id_width];
   end
endgenerate

endmodule

/* hdl/cmd_track_pkg.sv */
/* struct types shared by the tracker RTL and its testbench
   refer to them with cmd_track_pkg:: scoped names */
`include "cmd_track_macros.svh"

package cmd_track_pkg;

   // issue channel payload
   // only the host tag is carried, the slot is chosen by the table
   typedef struct packed
   {
      logic [`CMD_TAG_W-1:0] tag;
   } cmd_issue_t;

   // completion channel payload
   // names the slot handed out at issue time
   typedef struct packed
   {
      logic [`CMD_SLOT_W-1:0] slot;
   } cmd_cpl_t;

   // timeout event, also used for the oldest-command record
   // age is now minus the issue stamp, modulo CMD_TS_W
   typedef struct packed
   {
      logic [`CMD_SLOT_W-1:0] slot;
      logic [`CMD_TAG_W-1:0]  tag;
      logic [`CMD_TS_W-1:0]   age;
   } cmd_timeout_t;

   // register write request, takes effect on the next edge
   typedef struct packed
   {
      logic                   we;
      logic [`CMD_REG_AW-1:0] addr;
      logic [`CMD_TS_W-1:0]   wdata;
   } cmd_reg_req_t;

   // configuration seen by the monitor
   typedef struct packed
   {
      logic                 en;
      logic [`CMD_TS_W-1:0] thresh;
   } cmd_cfg_t;

endpackage

/* hdl/cmd_track_macros.svh */
/* sizing and register map for the command timeout tracker
   include wherever slot, tag, timestamp or register widths are needed */
`ifndef CMD_TRACK_MACROS_SVH
`define CMD_TRACK_MACROS_SVH

// number of tracked slots, power of two for the comparator tree
// (4 and 16 work as well)
`define CMD_SLOTS 8
// slot index width follows the slot count
`define CMD_SLOT_W $clog2(`CMD_SLOTS)

// command tag width
`define CMD_TAG_W 8

// timestamp and age width, ages wrap modulo this width
`define CMD_TS_W 16

// register map
`define CMD_REG_AW 2
`define CMD_REG_CTRL 2'd0
`define CMD_REG_THRESH 2'd1
// read only, saturating timeout count
`define CMD_REG_COUNT 2'd2

`endif
